// ==== logic/clock_pkg.sv ====
package clock_pkg;

	// ----------------------------------------
	// ranges
	// ----------------------------------------
	localparam int NUM_DIGITS = 6;

	localparam logic [5:0] SEC_MAX = 6'd59;
	localparam logic [5:0] MIN_MAX = 6'd59;
	localparam logic [5:0] HR_MAX  = 6'd23;

	// ----------------------------------------
	// control encodings
	// ----------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,	// normal run
		MODE_SETUP = 2'd1,	// clock stopped for editing
		MODE_ALARM = 2'd2	// alarm edit, clock keeps running
	} mode_e;

	typedef enum logic [1:0] {
		FIELD_SEC = 2'd0,
		FIELD_MIN = 2'd1,
		FIELD_HR  = 2'd2
	} field_e;

	// ----------------------------------------
	// bundles
	// ----------------------------------------
	typedef struct packed {
		logic [5:0] hr;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	typedef struct packed {
		logic mode;
		logic field;
		logic inc;
		logic alarm;
	} keys_t;	// one-cycle press pulses

	typedef struct packed {
		logic sec;
		logic min;
		logic hr;
	} field_inc_t;

	typedef logic [6:0] seg_t;	// segment a in the msb

	localparam seg_t SEG_BLANK = 7'b000_0000;

	// digit 0 is seconds ones
	typedef seg_t [NUM_DIGITS-1:0] digits_t;

endpackage

// ==== logic/tick_gen.sv ====
`timescale 1ns/100ps

module tick_gen #(
	parameter int unsigned DIV = 50000000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int unsigned CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;
	logic          last;	// terminal count

	assign last = (cnt == CW'(DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else begin
			cnt    <= last ? '0 : cnt + 1'b1;
			o_tick <= last;	// high for one clk
		end
	end

endmodule

// ==== logic/key_sampler.sv ====
`timescale 1ns/100ps

module key_sampler #(
	parameter int unsigned KEY_DIV = 500000
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [3:0]       i_btn,
	output clock_pkg::keys_t o_keys
);

	logic       key_tick;
	logic [3:0] samp_q1;	// newest sample
	logic [3:0] samp_q2;	// previous sample
	logic [3:0] press_q;

	tick_gen #(
		.DIV    (KEY_DIV)
	) u_key_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (key_tick)
	);

	// slow sampling rides over contact bounce
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_q1 <= 4'hf;	// buttons idle high
			samp_q2 <= 4'hf;
			press_q <= 4'h0;
		end else if (key_tick) begin
			samp_q1 <= i_btn;
			samp_q2 <= samp_q1;
			press_q <= samp_q2 & ~samp_q1;	// high then low
		end else begin
			press_q <= 4'h0;
		end
	end

	assign o_keys.mode  = press_q[0];
	assign o_keys.field = press_q[1];
	assign o_keys.inc   = press_q[2];
	assign o_keys.alarm = press_q[3];

endmodule

// ==== logic/mode_ctrl.sv ====
`timescale 1ns/100ps

module mode_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  clock_pkg::keys_t      i_keys,
	input  logic                  i_sec_tick,
	output clock_pkg::mode_e      o_mode,
	output clock_pkg::field_e     o_field,
	output logic                  o_alarm_en,
	output logic                  o_run,
	output clock_pkg::field_inc_t o_time_inc,
	output clock_pkg::field_inc_t o_alarm_inc
);

	clock_pkg::field_inc_t sel_inc;	// inc press on the selected field

	// ----------------------------------------
	// mode, field and alarm enable
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= clock_pkg::MODE_CLOCK;
			o_field    <= clock_pkg::FIELD_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (i_keys.mode) begin
				case (o_mode)
					clock_pkg::MODE_CLOCK: o_mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP: o_mode <= clock_pkg::MODE_ALARM;
					default:               o_mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (i_keys.field) begin
				case (o_field)
					clock_pkg::FIELD_SEC: o_field <= clock_pkg::FIELD_MIN;
					clock_pkg::FIELD_MIN: o_field <= clock_pkg::FIELD_HR;
					default:              o_field <= clock_pkg::FIELD_SEC;
				endcase
			end
			if (i_keys.alarm) begin
				o_alarm_en <= ~o_alarm_en;
			end
		end
	end

	// ----------------------------------------
	// strobe routing
	// ----------------------------------------
	always_comb begin
		sel_inc.sec = i_keys.inc && (o_field == clock_pkg::FIELD_SEC);
		sel_inc.min = i_keys.inc && (o_field == clock_pkg::FIELD_MIN);
		sel_inc.hr  = i_keys.inc && (o_field == clock_pkg::FIELD_HR);
	end

	always_comb begin
		o_run       = 1'b0;
		o_time_inc  = '0;
		o_alarm_inc = '0;
		case (o_mode)
			clock_pkg::MODE_CLOCK: o_run = i_sec_tick;
			clock_pkg::MODE_SETUP: o_time_inc = sel_inc;	// time frozen here
			clock_pkg::MODE_ALARM: begin
				o_run       = i_sec_tick;	// keeps running underneath
				o_alarm_inc = sel_inc;
			end
			default: o_run = 1'b0;
		endcase
	end

endmodule

// ==== logic/time_keeper.sv ====
`timescale 1ns/100ps

module time_keeper (
	input  logic                  clk,
	input  logic                  rst_n,
	input  clock_pkg::mode_e      i_mode,
	input  logic                  i_run,
	input  clock_pkg::field_inc_t i_time_inc,
	input  clock_pkg::field_inc_t i_alarm_inc,
	input  logic                  i_alarm_en,
	output clock_pkg::hms_t       o_disp,
	output logic                  o_alarm
);

	clock_pkg::hms_t clk_time;
	clock_pkg::hms_t alarm_time;
	logic            time_match;

	// step one field and wrap at its maximum
	function automatic logic [5:0] wrap_inc(
		input logic [5:0] val,
		input logic [5:0] max
	);
		return (val >= max) ? 6'd0 : val + 6'd1;
	endfunction

	// ----------------------------------------
	// running clock
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_time <= '0;
		end else if (i_run) begin
			clk_time.sec <= wrap_inc(clk_time.sec, clock_pkg::SEC_MAX);
			if (clk_time.sec == clock_pkg::SEC_MAX) begin
				clk_time.min <= wrap_inc(clk_time.min, clock_pkg::MIN_MAX);
				if (clk_time.min == clock_pkg::MIN_MAX) begin
					clk_time.hr <= wrap_inc(clk_time.hr, clock_pkg::HR_MAX);
				end
			end
		end else begin
			// set strobes touch one field only
			if (i_time_inc.sec) begin
				clk_time.sec <= wrap_inc(clk_time.sec, clock_pkg::SEC_MAX);
			end
			if (i_time_inc.min) begin
				clk_time.min <= wrap_inc(clk_time.min, clock_pkg::MIN_MAX);
			end
			if (i_time_inc.hr) begin
				clk_time.hr <= wrap_inc(clk_time.hr, clock_pkg::HR_MAX);
			end
		end
	end

	// ----------------------------------------
	// alarm time
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_time <= '0;
		end else begin
			if (i_alarm_inc.sec) begin
				alarm_time.sec <= wrap_inc(alarm_time.sec, clock_pkg::SEC_MAX);
			end
			if (i_alarm_inc.min) begin
				alarm_time.min <= wrap_inc(alarm_time.min, clock_pkg::MIN_MAX);
			end
			if (i_alarm_inc.hr) begin
				alarm_time.hr <= wrap_inc(alarm_time.hr, clock_pkg::HR_MAX);
			end
		end
	end

	assign o_disp = (i_mode == clock_pkg::MODE_ALARM) ? alarm_time : clk_time;

	// ----------------------------------------
	// alarm latch
	// ----------------------------------------
	assign time_match = (clk_time == alarm_time);	// all three fields

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			// sticky until the enable drops
			o_alarm <= i_alarm_en & (o_alarm | time_match);
		end
	end

endmodule

// ==== logic/digit_decoder.sv ====
`timescale 1ns/100ps

module digit_decoder (
	input  clock_pkg::hms_t    i_disp,
	output clock_pkg::digits_t o_digits
);

	// bcd digit to segments a..g
	function automatic clock_pkg::seg_t seg_of(input logic [3:0] num);
		case (num)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return clock_pkg::SEG_BLANK;	// out of range
		endcase
	endfunction

	// ----------------------------------------
	// tens / ones split
	// ----------------------------------------
	always_comb begin
		logic [5:0] fld;
		for (int i = 0; i < clock_pkg::NUM_DIGITS / 2; i++) begin
			fld = i_disp[6*i +: 6];	// sec at the lsb end, hr at the top
			o_digits[2*i]   = seg_of(4'(fld % 6'd10));
			o_digits[2*i+1] = seg_of(4'(fld / 6'd10));
		end
	end

endmodule

// ==== logic/display_scan.sv ====
`timescale 1ns/100ps

module display_scan #(
	parameter int unsigned SCAN_DIV  = 5000,
	parameter int unsigned BLINK_DIV = 12500000
) (
	input  logic               clk,
	input  logic               rst_n,
	input  clock_pkg::digits_t i_digits,
	input  clock_pkg::mode_e   i_mode,
	input  clock_pkg::field_e  i_field,
	output clock_pkg::seg_t    o_seg,
	output logic [5:0]         o_seg_enb
);

	logic       scan_tick;
	logic       blink_tick;
	logic [2:0] scan_idx;	// digit being driven
	logic       blink_phase;
	logic       editing;
	logic       blank;

	tick_gen #(
		.DIV    (SCAN_DIV)
	) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	tick_gen #(
		.DIV    (BLINK_DIV)
	) u_blink_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (blink_tick)
	);

	// ----------------------------------------
	// scan and blink state
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx    <= 3'd0;
			blink_phase <= 1'b0;
		end else begin
			if (scan_tick) begin
				scan_idx <= (scan_idx == 3'(clock_pkg::NUM_DIGITS - 1)) ? 3'd0 : scan_idx + 3'd1;
			end
			if (blink_tick) begin
				blink_phase <= ~blink_phase;
			end
		end
	end

	assign editing = (i_mode == clock_pkg::MODE_SETUP) || (i_mode == clock_pkg::MODE_ALARM);

	// digits 2k and 2k+1 belong to field k
	assign blank = editing && blink_phase && (scan_idx[2:1] == i_field);

	assign o_seg     = blank ? clock_pkg::SEG_BLANK : i_digits[scan_idx];
	assign o_seg_enb = ~(6'b00_0001 << scan_idx);	// active low, one hot

endmodule

// ==== logic/alarm_clock_top.sv ====
`timescale 1ns/100ps

module alarm_clock_top #(
	parameter int unsigned TICK_DIV  = 50000000,	// 1 Hz
	parameter int unsigned KEY_DIV   = 500000,	// 100 Hz
	parameter int unsigned SCAN_DIV  = 5000,
	parameter int unsigned BLINK_DIV = 12500000	// 4 Hz
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [3:0]      i_btn,
	output clock_pkg::seg_t o_seg,
	output logic [5:0]      o_seg_enb,
	output logic            o_alarm
);

	// ----------------------------------------
	// interconnect
	// ----------------------------------------
	logic                  sec_tick;
	clock_pkg::keys_t      keys;
	clock_pkg::mode_e      mode;
	clock_pkg::field_e     field;
	logic                  alarm_en;
	logic                  run;
	clock_pkg::field_inc_t time_inc;
	clock_pkg::field_inc_t alarm_inc;
	clock_pkg::hms_t       disp;
	clock_pkg::digits_t    digits;

	tick_gen #(
		.DIV    (TICK_DIV)
	) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	key_sampler #(
		.KEY_DIV (KEY_DIV)
	) u_key_sampler (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_btn   (i_btn),
		.o_keys  (keys)
	);

	mode_ctrl u_mode_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_keys      (keys),
		.i_sec_tick  (sec_tick),
		.o_mode      (mode),
		.o_field     (field),
		.o_alarm_en  (alarm_en),
		.o_run       (run),
		.o_time_inc  (time_inc),
		.o_alarm_inc (alarm_inc)
	);

	time_keeper u_time_keeper (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_mode      (mode),
		.i_run       (run),
		.i_time_inc  (time_inc),
		.i_alarm_inc (alarm_inc),
		.i_alarm_en  (alarm_en),
		.o_disp      (disp),
		.o_alarm     (o_alarm)
	);

	digit_decoder u_digit_decoder (
		.i_disp   (disp),
		.o_digits (digits)
	);

	display_scan #(
		.SCAN_DIV  (SCAN_DIV),
		.BLINK_DIV (BLINK_DIV)
	) u_display_scan (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_digits  (digits),
		.i_mode    (mode),
		.i_field   (field),
		.o_seg     (o_seg),
		.o_seg_enb (o_seg_enb)
	);

endmodule

// ==== tb/alarm_clock_sva.sv ====
`timescale 1ns/100ps

module alarm_clock_sva (
	input logic              clk,
	input logic              rst_n,
	input clock_pkg::mode_e  i_mode,
	input logic              i_alarm_en,
	input clock_pkg::hms_t   clk_time,
	input clock_pkg::hms_t   alarm_time,
	input clock_pkg::hms_t   o_disp,
	input logic              o_alarm
);

	// ----------------------------------------
	// field ranges
	// ----------------------------------------
	a_clk_range: assert property (@(posedge clk) disable iff (!rst_n)
		clk_time.sec <= clock_pkg::SEC_MAX && clk_time.min <= clock_pkg::MIN_MAX
		&& clk_time.hr <= clock_pkg::HR_MAX)
		else $error("clock time field out of range");

	a_alarm_range: assert property (@(posedge clk) disable iff (!rst_n)
		alarm_time.sec <= clock_pkg::SEC_MAX && alarm_time.min <= clock_pkg::MIN_MAX
		&& alarm_time.hr <= clock_pkg::HR_MAX)
		else $error("alarm time field out of range");

	// latch must drop with the enable
	a_alarm_off: assert property (@(posedge clk) disable iff (!rst_n)
		!i_alarm_en |=> !o_alarm)
		else $error("alarm high after enable was low");

	a_disp_alarm: assert property (@(posedge clk) disable iff (!rst_n)
		(i_mode == clock_pkg::MODE_ALARM) |-> (o_disp == alarm_time))
		else $error("display does not show the alarm time in alarm mode");

endmodule

bind time_keeper alarm_clock_sva u_sva (
	.clk        (clk),
	.rst_n      (rst_n),
	.i_mode     (i_mode),
	.i_alarm_en (i_alarm_en),
	.clk_time   (clk_time),
	.alarm_time (alarm_time),
	.o_disp     (o_disp),
	.o_alarm    (o_alarm)
);

// ==== tb/alarm_clock_tb.sv ====
`timescale 1ns/100ps

module alarm_clock_tb;

	localparam int TICK_DIV  = 400;
	localparam int KEY_DIV   = 4;
	localparam int SCAN_DIV  = 2;
	localparam int BLINK_DIV = 64;

	localparam logic [1:0] BTN_MODE  = 2'd0;
	localparam logic [1:0] BTN_FIELD = 2'd1;
	localparam logic [1:0] BTN_INC   = 2'd2;
	localparam logic [1:0] BTN_ALARM = 2'd3;

	localparam clock_pkg::hms_t ALARM_AT = {6'd0, 6'd0, 6'd5};

	logic               clk;
	logic               rst_n;
	logic [3:0]         i_btn;
	clock_pkg::seg_t    o_seg;
	logic [5:0]         o_seg_enb;
	logic               o_alarm;
	int                 seed;
	bit                 reported;	// a final verdict was printed
	clock_pkg::hms_t    t;
	int                 n;

	alarm_clock_top #(
		.TICK_DIV  (TICK_DIV),
		.KEY_DIV   (KEY_DIV),
		.SCAN_DIV  (SCAN_DIV),
		.BLINK_DIV (BLINK_DIV)
	) uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_btn     (i_btn),
		.o_seg     (o_seg),
		.o_seg_enb (o_seg_enb),
		.o_alarm   (o_alarm)
	);

	always #10 clk = ~clk;

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic clock_pkg::seg_t seg_of(input int d);
		case (d)
			0:       return 7'b1111110;
			1:       return 7'b0110000;
			2:       return 7'b1101101;
			3:       return 7'b1111001;
			4:       return 7'b0110011;
			5:       return 7'b1011011;
			6:       return 7'b1011111;
			7:       return 7'b1110000;
			8:       return 7'b1111111;
			9:       return 7'b1110011;
			default: return clock_pkg::SEG_BLANK;
		endcase
	endfunction

	function automatic clock_pkg::digits_t hms_to_digits(input clock_pkg::hms_t v);
		clock_pkg::digits_t d;
		d[0] = seg_of(int'(v.sec) % 10);
		d[1] = seg_of(int'(v.sec) / 10);
		d[2] = seg_of(int'(v.min) % 10);
		d[3] = seg_of(int'(v.min) / 10);
		d[4] = seg_of(int'(v.hr) % 10);
		d[5] = seg_of(int'(v.hr) / 10);
		return d;
	endfunction

	function automatic clock_pkg::hms_t next_second(input clock_pkg::hms_t v);
		clock_pkg::hms_t r;
		r = v;
		if (v.sec == 6'd59) begin
			r.sec = 6'd0;
			if (v.min == 6'd59) begin
				r.min = 6'd0;
				r.hr  = (v.hr == 6'd23) ? 6'd0 : v.hr + 6'd1;	// midnight
			end else begin
				r.min = v.min + 6'd1;
			end
		end else begin
			r.sec = v.sec + 6'd1;
		end
		return r;
	endfunction

	// n set presses on one field without carry
	function automatic clock_pkg::hms_t add_field(input clock_pkg::hms_t v,
			input clock_pkg::field_e f, input int cnt);
		clock_pkg::hms_t r;
		r = v;
		case (f)
			clock_pkg::FIELD_SEC: r.sec = 6'((int'(v.sec) + cnt) % 60);
			clock_pkg::FIELD_MIN: r.min = 6'((int'(v.min) + cnt) % 60);
			default:              r.hr  = 6'((int'(v.hr) + cnt) % 24);
		endcase
		return r;
	endfunction

	function automatic int field_val(input clock_pkg::hms_t v, input clock_pkg::field_e f);
		case (f)
			clock_pkg::FIELD_SEC: return int'(v.sec);
			clock_pkg::FIELD_MIN: return int'(v.min);
			default:              return int'(v.hr);
		endcase
	endfunction

	// ----------------------------------------
	// failure and compare
	// ----------------------------------------
	task automatic stop_with_failure(input string why);
		reported = 1'b1;
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	// selected field may be blanked while editing
	task automatic check_digits(input clock_pkg::digits_t got, input clock_pkg::digits_t want,
			input logic editing, input clock_pkg::field_e fld);
		for (int i = 0; i < clock_pkg::NUM_DIGITS; i++) begin
			if (got[i] !== want[i] && !(editing && i / 2 == int'(fld)
					&& got[i] == clock_pkg::SEG_BLANK)) begin
				stop_with_failure($sformatf("Error at %0t: digit %0d is %b, expected %b",
					$time, i, got[i], want[i]));
			end
		end
	endtask

	task automatic check_alarm(input logic want);
		if (o_alarm !== want) begin
			stop_with_failure($sformatf("Error at %0t: o_alarm is %b, expected %b",
				$time, o_alarm, want));
		end
	endtask

	// ----------------------------------------
	// stimulus and display reading
	// ----------------------------------------
	task automatic press(input logic [1:0] b);
		i_btn[b] = 1'b0;
		repeat (4 * KEY_DIV) @(negedge clk);
		i_btn[b] = 1'b1;
		repeat (4 * KEY_DIV) @(negedge clk);
	endtask

	// one pass over all six digits
	task automatic read_display(output clock_pkg::digits_t d);
		logic [5:0] seen;
		int         cyc;
		seen = '0;
		cyc  = 0;
		while (seen != 6'h3f) begin
			@(negedge clk);
			if ($countones(o_seg_enb) != clock_pkg::NUM_DIGITS - 1) begin
				stop_with_failure("digit enables are not one hot");
			end
			for (int i = 0; i < clock_pkg::NUM_DIGITS; i++) begin
				if (!o_seg_enb[i]) begin
					d[i]    = o_seg;
					seen[i] = 1'b1;
				end
			end
			cyc++;
			if (cyc > 20 * SCAN_DIV * clock_pkg::NUM_DIGITS) begin
				stop_with_failure("digit enables did not scan all six digits");
			end
		end
	endtask

	// two equal passes in a row so no tick falls inside
	task automatic read_stable(output clock_pkg::digits_t d);
		clock_pkg::digits_t prev;
		int                 tries;
		tries = 0;
		read_display(prev);
		read_display(d);
		while (d != prev) begin
			prev = d;
			read_display(d);
			tries++;
			if (tries > 20) begin
				stop_with_failure("display reading did not settle");
			end
		end
	endtask

	// starts and ends on the seconds field
	task automatic set_time(input clock_pkg::hms_t cur, input clock_pkg::hms_t tgt);
		clock_pkg::hms_t    v;
		clock_pkg::field_e  f;
		clock_pkg::digits_t got;
		v = cur;
		for (int k = 0; k < 3; k++) begin
			f = clock_pkg::field_e'(k);
			while (field_val(v, f) != field_val(tgt, f)) begin
				press(BTN_INC);
				v = add_field(v, f, 1);
			end
			read_display(got);
			check_digits(got, hms_to_digits(v), 1'b1, f);
			press(BTN_FIELD);
		end
	endtask

	// each reading is the last time or one second on
	task automatic track_running(inout clock_pkg::hms_t v, input clock_pkg::hms_t stop);
		clock_pkg::digits_t got;
		int                 reads;
		reads = 0;
		while (v != stop) begin
			read_stable(got);
			if (got == hms_to_digits(next_second(v))) begin
				v = next_second(v);
			end
			check_digits(got, hms_to_digits(v), 1'b0, clock_pkg::FIELD_SEC);
			reads++;
			if (reads > 400) begin
				stop_with_failure("running clock did not reach the expected time");
			end
		end
	endtask

	final begin
		if (!reported) begin
			$display("run ended before the test completed");
			$display("TEST RESULT: FAIL");
		end
	end

	initial begin
		clock_pkg::digits_t got;
		clock_pkg::hms_t    exp_t;
		clock_pkg::field_e  f;
		int                 cnt;
		int                 k;

		clk      = 1'b0;
		rst_n    = 1'b0;
		i_btn    = 4'hf;	// idle high
		seed     = 32'hcfa8_c8d3;
		reported = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		if (o_seg_enb !== 6'b11_1110) begin
			stop_with_failure("digit 0 is not enabled after reset");
		end

		// reset state
		exp_t = '0;
		read_stable(got);
		check_digits(got, hms_to_digits(exp_t), 1'b0, clock_pkg::FIELD_SEC);
		check_alarm(1'b0);

		// setup edits while the clock is frozen before the first second tick
		press(BTN_MODE);
		for (int i = 0; i < 3; i++) begin
			f   = clock_pkg::field_e'(i);
			cnt = $unsigned($random(seed)) % 70;
			repeat (cnt) press(BTN_INC);
			exp_t = add_field(exp_t, f, cnt);
			repeat (40) begin	// spans more than one second
				read_display(got);
				check_digits(got, hms_to_digits(exp_t), 1'b1, f);
			end
			press(BTN_FIELD);
		end

		// ----------------------------------------
		// roll over midnight
		// ----------------------------------------
		t = {6'd23, 6'd59, 6'd57};
		set_time(exp_t, t);
		press(BTN_MODE);	// alarm mode with the clock running
		press(BTN_MODE);	// clock mode
		track_running(t, '0);

		// alarm edits while the clock runs underneath
		press(BTN_MODE);	// setup with the clock frozen at midnight
		press(BTN_MODE);
		set_time('0, ALARM_AT);
		repeat (40) begin
			read_display(got);
			check_digits(got, hms_to_digits(ALARM_AT), 1'b1, clock_pkg::FIELD_SEC);
		end
		press(BTN_MODE);
		read_stable(got);
		t = '0;
		k = 0;
		while (got != hms_to_digits(t) && k < 60) begin
			t = next_second(t);
			k++;
		end
		if (k == 0 || k == 60) begin
			stop_with_failure("clock did not keep running during alarm edits");
		end
		track_running(t, next_second(t));	// lands just after a tick

		// ----------------------------------------
		// alarm match
		// ----------------------------------------
		press(BTN_MODE);
		set_time(t, {6'd0, 6'd0, 6'd3});
		press(BTN_ALARM);	// enable
		check_alarm(1'b0);
		press(BTN_MODE);
		press(BTN_MODE);
		n = 0;
		while (o_alarm !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > 5 * TICK_DIV) begin
				stop_with_failure("alarm output did not rise at the alarm time");
			end
		end
		repeat (10) begin	// runs well past the matching second
			repeat (TICK_DIV / 4) @(negedge clk);
			check_alarm(1'b1);
		end
		press(BTN_ALARM);	// disable clears the latch
		check_alarm(1'b0);

		reported = 1'b1;
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== verilog.f ====
logic/clock_pkg.sv
logic/tick_gen.sv
logic/key_sampler.sv
logic/mode_ctrl.sv
logic/time_keeper.sv
logic/digit_decoder.sv
logic/display_scan.sv
logic/alarm_clock_top.sv
tb/alarm_clock_sva.sv
tb/alarm_clock_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= alarm_clock_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
